// ==== common/clk_mon_consts.svh ====
`ifndef CLK_MON_CONSTS_SVH
`define CLK_MON_CONSTS_SVH

// Gate length in ps_clk cycles, one second at 100 MHz
`define CLK_MON_GATE_CYCLES 100000000

// Width of one frequency reading
`define CLK_MON_COUNT_W 32

// Flops in each synchronizer chain
`define CLK_MON_SYNC_STAGES 2

// Round trip through both flag crossings must fit inside one gate
`define CLK_MON_MIN_GATE 64

`endif

// ==== common/clk_mon_types_pkg.sv ====
`include "clk_mon_consts.svh"

package clk_mon_types_pkg;

    // Edge count of one measured clock over a gate
    typedef logic [`CLK_MON_COUNT_W-1:0] count_t;

    // Measured channel index
    typedef logic chan_t;

    localparam chan_t CHAN_ADC = 1'b0;  // Sample clock
    localparam chan_t CHAN_REF = 1'b1;  // Capture reference clock

endpackage

// ==== common/clk_mon_ctrl_pkg.sv ====
package clk_mon_ctrl_pkg;

    // Sequencer states
    //  IDLE     monitor disabled, outputs hold
    //  PRIME    waiting for the first gate, whose window is thrown away
    //  MEASURE  window open, collecting done flags
    //  PUBLISH  one cycle, results valid
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        PRIME   = 2'd1,
        MEASURE = 2'd2,
        PUBLISH = 2'd3
    } seq_state_t;

endpackage

// ==== design/gate_timer.sv ====
`timescale 1ns/1ns
`include "clk_mon_consts.svh"

module gate_timer #(
    parameter int GATE_CYCLES = `CLK_MON_GATE_CYCLES
) (
    input  logic ps_clk,
    input  logic reset_i,
    input  logic enable_i,
    output logic gate_tick_o
);

    // Shorter gates would let a pulse overtake the previous crossing
    localparam int GATE_LEN = (GATE_CYCLES < `CLK_MON_MIN_GATE) ?
                              `CLK_MON_MIN_GATE : GATE_CYCLES;
    localparam int CNT_W    = $clog2(GATE_LEN);

    logic [CNT_W-1:0] gate_cnt;
    logic             wrap;

    assign wrap = (gate_cnt == CNT_W'(GATE_LEN - 1));

    always_ff @(posedge ps_clk) begin
        if (reset_i || !enable_i) begin
            gate_cnt    <= '0;
            gate_tick_o <= 1'b0;
        end else begin
            if (wrap) begin
                gate_cnt <= '0;
            end else begin
                gate_cnt <= gate_cnt + 1'b1;
            end
            gate_tick_o <= wrap;    // One cycle per period
        end
    end

endmodule

// ==== design/flag_sync.sv ====
`timescale 1ns/1ns
`include "clk_mon_consts.svh"

module flag_sync #(
    parameter int STAGES = `CLK_MON_SYNC_STAGES
) (
    input  logic clk_a_i,
    input  logic pulse_a_i,
    input  logic clk_b_i,
    output logic pulse_b_o
);

    logic              toggle_a = 1'b0;
    logic [STAGES-1:0] sync_b   = '0;
    logic              last_b   = 1'b0;

    // Each source pulse flips the level
    always_ff @(posedge clk_a_i) begin
        toggle_a <= toggle_a ^ pulse_a_i;
    end

    always_ff @(posedge clk_b_i) begin
        sync_b <= {sync_b[STAGES-2:0], toggle_a};
        last_b <= sync_b[STAGES-1];
    end

    // Any change of the synchronized level is one pulse
    assign pulse_b_o = sync_b[STAGES-1] ^ last_b;

endmodule

// ==== design/edge_counter.sv ====
`timescale 1ns/1ns

module edge_counter import clk_mon_types_pkg::*; (
    input  logic   meas_clk_i,
    input  logic   gate_i,
    output count_t count_o,
    output logic   done_o
);

    count_t run_cnt;
    logic   done_q = 1'b0;

    always_ff @(posedge meas_clk_i) begin
        if (gate_i) begin
            count_o <= run_cnt;
            run_cnt <= count_t'(1);     // Gate edge belongs to the new window
        end else begin
            run_cnt <= run_cnt + 1'b1;
        end
        done_q <= gate_i;
    end

    // Echo of the gate, count_o already holds the new value
    assign done_o = done_q;

endmodule

// ==== design/measure_seq.sv ====
`timescale 1ns/1ns

module measure_seq import clk_mon_types_pkg::*, clk_mon_ctrl_pkg::*; (
    input  logic       ps_clk,
    input  logic       reset_i,
    input  logic       enable_i,
    input  logic       gate_tick_i,
    input  logic [1:0] done_i,
    input  count_t     count_adc_i,
    input  count_t     count_ref_i,
    output logic       gate_pulse_o,
    output count_t     freq_adc_o,
    output count_t     freq_ref_o,
    output logic       result_valid_o,
    output logic       adc_missing_o,
    output logic       ref_missing_o
);

    seq_state_t state_q;
    seq_state_t state_nxt;
    logic       open_q;     // A result is owed for the last gate
    logic [1:0] got_q;      // Channels that returned done this window
    logic [1:0] got_nxt;
    count_t     cap_adc_q;
    count_t     cap_ref_q;
    logic       issue_gate;
    logic       publish;

    assign got_nxt = got_q | (done_i & {2{open_q}});

    always_comb begin
        state_nxt  = state_q;
        issue_gate = 1'b0;
        publish    = 1'b0;
        case (state_q)
            IDLE: begin
                if (enable_i) state_nxt = PRIME;
            end
            PRIME: begin
                if (!enable_i) begin
                    state_nxt = IDLE;
                end else if (gate_tick_i) begin
                    issue_gate = 1'b1;      // Starts the counters, nothing owed yet
                    state_nxt  = MEASURE;
                end
            end
            default: begin
                state_nxt = MEASURE;
                if (!enable_i) begin
                    state_nxt = IDLE;
                end else if (gate_tick_i) begin
                    issue_gate = 1'b1;
                    publish    = open_q;    // Late channels are missing
                end else begin
                    publish = open_q && (got_q == 2'b11);
                end
                if (publish) state_nxt = PUBLISH;
            end
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state_q       <= IDLE;
            open_q        <= 1'b0;
            got_q         <= 2'b00;
            gate_pulse_o  <= 1'b0;
            freq_adc_o    <= '0;
            freq_ref_o    <= '0;
            adc_missing_o <= 1'b0;
            ref_missing_o <= 1'b0;
        end else begin
            state_q      <= state_nxt;
            gate_pulse_o <= issue_gate;

            if (!enable_i) begin
                open_q <= 1'b0;
            end else if (issue_gate) begin
                open_q <= (state_q != PRIME);
            end else if (publish) begin
                open_q <= 1'b0;
            end

            got_q <= issue_gate ? 2'b00 : got_nxt;

            if (publish) begin
                freq_adc_o    <= got_q[CHAN_ADC] ? cap_adc_q : '0;
                freq_ref_o    <= got_q[CHAN_REF] ? cap_ref_q : '0;
                adc_missing_o <= !got_q[CHAN_ADC];
                ref_missing_o <= !got_q[CHAN_REF];
            end
        end
    end

    // Held counts are stable for a full gate after done
    always_ff @(posedge ps_clk) begin
        if (open_q && done_i[CHAN_ADC]) cap_adc_q <= count_adc_i;
        if (open_q && done_i[CHAN_REF]) cap_ref_q <= count_ref_i;
    end

    assign result_valid_o = (state_q == PUBLISH);

endmodule

// ==== design/clk_mon_top.sv ====
`timescale 1ns/1ns
`include "clk_mon_consts.svh"

module clk_mon_top import clk_mon_types_pkg::*; #(
    parameter int GATE_CYCLES = `CLK_MON_GATE_CYCLES
) (
    input  logic   ps_clk,
    input  logic   reset_i,
    input  logic   enable_i,
    input  logic   adc_clk_i,
    input  logic   ref_clk_i,
    output count_t freq_adc_o,
    output count_t freq_ref_o,
    output logic   result_valid_o,
    output logic   adc_missing_o,
    output logic   ref_missing_o
);

    logic       gate_tick;
    logic       gate_pulse;
    logic       gate_adc;       // adc_clk domain
    logic       gate_ref;       // ref_clk domain
    logic       done_adc_meas;
    logic       done_ref_meas;
    logic [1:0] done;           // Back in ps_clk, indexed by chan_t
    count_t     count_adc;
    count_t     count_ref;

    gate_timer #(
        .GATE_CYCLES(GATE_CYCLES)
    ) u_timer (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .enable_i    (enable_i),
        .gate_tick_o (gate_tick)
    );

    measure_seq u_seq (
        .ps_clk         (ps_clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .gate_tick_i    (gate_tick),
        .done_i         (done),
        .count_adc_i    (count_adc),
        .count_ref_i    (count_ref),
        .gate_pulse_o   (gate_pulse),
        .freq_adc_o     (freq_adc_o),
        .freq_ref_o     (freq_ref_o),
        .result_valid_o (result_valid_o),
        .adc_missing_o  (adc_missing_o),
        .ref_missing_o  (ref_missing_o)
    );

    // Gate out to the measured domains
    flag_sync u_adc_gate_sync (
        .clk_a_i   (ps_clk),
        .pulse_a_i (gate_pulse),
        .clk_b_i   (adc_clk_i),
        .pulse_b_o (gate_adc)
    );

    flag_sync u_ref_gate_sync (
        .clk_a_i   (ps_clk),
        .pulse_a_i (gate_pulse),
        .clk_b_i   (ref_clk_i),
        .pulse_b_o (gate_ref)
    );

    edge_counter u_adc_cnt (
        .meas_clk_i (adc_clk_i),
        .gate_i     (gate_adc),
        .count_o    (count_adc),
        .done_o     (done_adc_meas)
    );

    edge_counter u_ref_cnt (
        .meas_clk_i (ref_clk_i),
        .gate_i     (gate_ref),
        .count_o    (count_ref),
        .done_o     (done_ref_meas)
    );

    // Echo back to ps_clk
    flag_sync u_adc_done_sync (
        .clk_a_i   (adc_clk_i),
        .pulse_a_i (done_adc_meas),
        .clk_b_i   (ps_clk),
        .pulse_b_o (done[CHAN_ADC])
    );

    flag_sync u_ref_done_sync (
        .clk_a_i   (ref_clk_i),
        .pulse_a_i (done_ref_meas),
        .clk_b_i   (ps_clk),
        .pulse_b_o (done[CHAN_REF])
    );

endmodule

// ==== bench/clk_mon_properties.sv ====
`timescale 1ns/1ns

module clk_mon_properties import clk_mon_types_pkg::*; (
    input logic       ps_clk,
    input logic       reset_i,
    input logic       enable_i,
    input logic       result_valid_i,
    input count_t     freq_adc_i,
    input count_t     freq_ref_i
);

    single_pulse_a: assert property (@(posedge ps_clk) disable iff (reset_i)
        result_valid_i |=> !result_valid_i)
        else $error("result_valid_o stayed high for more than one cycle");

    // Disabled monitor publishes nothing
    quiet_when_off_a: assert property (@(posedge ps_clk) disable iff (reset_i)
        !enable_i |-> !result_valid_i)
        else $error("result_valid_o fired while enable_i was low");

    adc_stable_a: assert property (@(posedge ps_clk) disable iff (reset_i)
        !$stable(freq_adc_i) |-> result_valid_i)
        else $error("freq_adc_o changed without result_valid_o");

    ref_stable_a: assert property (@(posedge ps_clk) disable iff (reset_i)
        !$stable(freq_ref_i) |-> result_valid_i)
        else $error("freq_ref_o changed without result_valid_o");

endmodule

bind clk_mon_top clk_mon_properties u_props (
    .ps_clk         (ps_clk),
    .reset_i        (reset_i),
    .enable_i       (enable_i),
    .result_valid_i (result_valid_o),
    .freq_adc_i     (freq_adc_o),
    .freq_ref_i     (freq_ref_o)
);

// ==== bench/clk_mon_tb.sv ====
`timescale 1ns/1ns

module clk_mon_tb import clk_mon_types_pkg::*; ();

    localparam int GATE        = 200;
    localparam int PS_PERIOD   = 20;
    localparam int GATE_NS     = GATE * PS_PERIOD;
    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * 6 * GATE_NS + 16 * PS_PERIOD;

    logic   ps_clk  = 1'b0;
    logic   reset   = 1'b1;
    logic   enable  = 1'b0;
    logic   adc_clk = 1'b0;
    logic   ref_clk = 1'b0;
    count_t freq_adc;
    count_t freq_ref;
    logic   result_valid;
    logic   adc_missing;
    logic   ref_missing;

    int     seed;
    int     adc_half = 5;           // ns
    int     ref_half = 7;
    logic   adc_run  = 1'b1;
    int     exp_adc  = 0;
    int     exp_ref  = 0;
    count_t held_adc = '0;
    count_t held_ref = '0;

    // Check enables, moved 2 ns after the clock edge
    logic   chk_reset_vals = 1'b0;
    logic   expect_quiet   = 1'b0;
    logic   chk_adc        = 1'b0;
    logic   chk_ref        = 1'b0;
    logic   hold_chk       = 1'b0;

    int     error_count  = 0;
    int     pass_count   = 0;
    int     fail_count   = 0;
    int     errs_at_start;
    int     test_num     = 0;
    string  test_name;
    bit     run_reported = 1'b0;

    always #(PS_PERIOD / 2) ps_clk = ~ps_clk;
    always #(adc_half) adc_clk = adc_run ? ~adc_clk : adc_clk;
    always #(ref_half) ref_clk = ~ref_clk;

    clk_mon_top #(
        .GATE_CYCLES(GATE)
    ) UUT (
        .ps_clk         (ps_clk),
        .reset_i        (reset),
        .enable_i       (enable),
        .adc_clk_i      (adc_clk),
        .ref_clk_i      (ref_clk),
        .freq_adc_o     (freq_adc),
        .freq_ref_o     (freq_ref),
        .result_valid_o (result_valid),
        .adc_missing_o  (adc_missing),
        .ref_missing_o  (ref_missing)
    );

    // Rising edges of a clock with this half period inside one gate
    function automatic int expected_count(input int half);
        return GATE_NS / (2 * half);
    endfunction

    function automatic bit within_tol(input count_t value, input int expected);
        int diff;
        diff = int'(value) - expected;
        return (diff >= -2) && (diff <= 2);
    endfunction

    reset_vals_a: assert property (@(posedge ps_clk) chk_reset_vals |->
        (!result_valid && !adc_missing && !ref_missing && freq_adc == '0 && freq_ref == '0))
        else begin
            $display("[ERROR] %0t ns: outputs left their reset values", $time);
            error_count++;
        end

    quiet_a: assert property (@(posedge ps_clk) expect_quiet |-> !result_valid)
        else begin
            $display("[ERROR] %0t ns: result_valid_o fired in a quiet window", $time);
            error_count++;
        end

    adc_value_a: assert property (@(posedge ps_clk) (result_valid && chk_adc) |->
        (!adc_missing && within_tol(freq_adc, exp_adc)))
        else begin
            $display("[ERROR] %0t ns: freq_adc_o = %0d, expected %0d +/- 2", $time,
                     $sampled(freq_adc), exp_adc);
            error_count++;
        end

    ref_value_a: assert property (@(posedge ps_clk) (result_valid && chk_ref) |->
        (!ref_missing && within_tol(freq_ref, exp_ref)))
        else begin
            $display("[ERROR] %0t ns: freq_ref_o = %0d, expected %0d +/- 2", $time,
                     $sampled(freq_ref), exp_ref);
            error_count++;
        end

    missing_zero_a: assert property (@(posedge ps_clk) (result_valid && adc_missing) |->
        freq_adc == '0)
        else begin
            $display("[ERROR] %0t ns: freq_adc_o not zero with adc_missing_o", $time);
            error_count++;
        end

    hold_a: assert property (@(posedge ps_clk) hold_chk |->
        (freq_adc == held_adc && freq_ref == held_ref))
        else begin
            $display("[ERROR] %0t ns: outputs changed while disabled", $time);
            error_count++;
        end

    task automatic after_edge();
        @(posedge ps_clk);
        #2;
    endtask

    task automatic pick_half(output int half);
        int rnd;
        rnd = $random(seed);
        half = 3 + int'((rnd & 32'h7fff_ffff) % 10);   // 6 to 24 ns period
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name     = name;
        errs_at_start = error_count;
    endtask

    task automatic close_test();
        after_edge();       // Last result is checked on this edge
        if (error_count == errs_at_start) begin
            pass_count++;
            $display("Test %0d %s: ok", test_num, test_name);
        end else begin
            fail_count++;
            $display("Test %0d %s: failed", test_num, test_name);
        end
    endtask

    // Returns at the falling edge where result_valid_o is seen high
    task automatic wait_result(input int max_gates);
        int waited;
        waited = 0;
        @(negedge ps_clk);
        while (!result_valid && waited < max_gates * GATE) begin
            @(negedge ps_clk);
            waited++;
        end
        if (!result_valid) begin
            $display("No result arrived within %0d gate periods", max_gates);
            error_count++;
        end
    endtask

    task automatic wait_adc_flag(input logic level, input int max_gates);
        int waited;
        waited = 0;
        @(negedge ps_clk);
        while (!(result_valid && adc_missing == level) && waited < max_gates * GATE) begin
            @(negedge ps_clk);
            waited++;
        end
        if (!(result_valid && adc_missing == level)) begin
            $display("adc_missing_o did not go %0s within %0d gate periods",
                     level ? "high" : "low", max_gates);
            error_count++;
        end
    endtask

    initial begin
        int new_half;
        seed = 32'h6e84_37d2;
        pick_half(adc_half);
        pick_half(ref_half);
        exp_adc = expected_count(adc_half);
        exp_ref = expected_count(ref_half);
        repeat (16) @(posedge ps_clk);
        #2;
        reset = 1'b0;

        start_test("reset and priming");
        chk_reset_vals = 1'b1;
        expect_quiet   = 1'b1;
        repeat (4) after_edge();
        enable = 1'b1;
        repeat (2 * GATE) @(posedge ps_clk);   // Up to the second gate tick
        #2;
        chk_reset_vals = 1'b0;
        expect_quiet   = 1'b0;
        wait_result(2);
        close_test();

        start_test("adc count");
        after_edge();
        chk_adc = 1'b1;
        wait_result(2);
        wait_result(2);
        close_test();

        start_test("ref count");
        after_edge();
        chk_ref = 1'b1;
        wait_result(2);
        wait_result(2);
        close_test();

        start_test("ref period change");
        after_edge();
        pick_half(new_half);
        if (new_half == ref_half) new_half = (new_half == 12) ? 3 : new_half + 1;
        ref_half = new_half;
        chk_ref  = 1'b0;                        // Next window straddles the change
        wait_result(2);
        after_edge();
        exp_ref = expected_count(ref_half);
        chk_ref = 1'b1;
        wait_result(2);
        close_test();

        start_test("adc clock loss");
        after_edge();
        adc_run = 1'b0;
        chk_adc = 1'b0;
        wait_adc_flag(1'b1, 2);
        after_edge();
        adc_run = 1'b1;
        wait_adc_flag(1'b0, 3);
        wait_result(2);                         // May still hold a partial window
        after_edge();
        chk_adc = 1'b1;
        wait_result(2);
        close_test();

        start_test("enable low");
        after_edge();
        enable       = 1'b0;
        held_adc     = freq_adc;
        held_ref     = freq_ref;
        hold_chk     = 1'b1;
        expect_quiet = 1'b1;
        repeat (3 * GATE) @(posedge ps_clk);
        #2;
        hold_chk     = 1'b0;
        expect_quiet = 1'b0;
        close_test();

        $display("Tests run: %0d, passed: %0d, failed: %0d", test_num, pass_count, fail_count);
        run_reported = 1'b1;
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        run_reported = 1'b1;
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // A failing bound assertion stops the run early
    final begin
        if (!run_reported) begin
            $display("Simulation stopped before the tests completed");
            $display("TESTS FAILED");
        end
    end

endmodule

// ==== clk_mon_top.f ====
+incdir+common
common/clk_mon_types_pkg.sv
common/clk_mon_ctrl_pkg.sv
design/gate_timer.sv
design/flag_sync.sv
design/edge_counter.sv
design/measure_seq.sv
design/clk_mon_top.sv
bench/clk_mon_properties.sv
bench/clk_mon_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the clk_mon testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module clk_mon_tb \
    -f clk_mon_top.f \
    -o clk_mon_sim

out=$(./obj_dir/clk_mon_sim)
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
else
    exit 1
fi
